//--- bench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

	localparam int n_instr = 100; // upper bound on words issued by the tests
	localparam mips_isa_pkg::word_t filler = 32'hfc00_0000; // unused opcode, writes nothing

	logic                      clk = 1'b0;
	logic                      rst;
	mips_isa_pkg::word_t       id_pc;
	mips_isa_pkg::word_t       id_inst;
	mips_isa_pkg::word_t       rf_data1;
	mips_isa_pkg::word_t       rf_data2;
	mips_isa_pkg::word_t       ex_wdata;
	mips_pipe_pkg::fwd_t       mem_fwd;
	mips_pipe_pkg::rf_req_t    rf_req;
	logic                      stall;
	mips_pipe_pkg::branch_t    branch;
	mips_pipe_pkg::ex_bundle_t ex;

	mips_isa_pkg::word_t regs [32]; // register file model
	mips_pipe_pkg::fwd_t mem_src;   // memory-stage writer for the next edge
	mips_isa_pkg::word_t next_pc;
	mips_isa_pkg::word_t ex_val;    // execute result driven on the last edge
	logic [31:0]         seed = 32'd88394;
	int                  n_checks = 0;
	int                  n_errors = 0;

	always #4 clk = ~clk;

	assign rf_data1 = regs[rf_req.addr1];
	assign rf_data2 = regs[rf_req.addr2];

	id_stage uut (
		.clk        (clk),
		.rst_i      (rst),
		.pc_i       (id_pc),
		.inst_i     (id_inst),
		.rf_data1_i (rf_data1),
		.rf_data2_i (rf_data2),
		.ex_wdata_i (ex_wdata),
		.mem_fwd_i  (mem_fwd),
		.rf_req_o   (rf_req),
		.stall_o    (stall),
		.branch_o   (branch),
		.ex_o       (ex)
	);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic mips_isa_pkg::word_t enc_r(logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] shamt, logic [5:0] funct);
		return {6'b000000, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mips_isa_pkg::word_t enc_i(logic [5:0] op, logic [4:0] rs,
		logic [4:0] rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_isa_pkg::word_t enc_j(logic [5:0] op, logic [25:0] index);
		return {op, index};
	endfunction

	// targets for a word issued at next_pc
	function automatic mips_isa_pkg::word_t rel_target(logic [15:0] off);
		return next_pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
	endfunction

	function automatic mips_isa_pkg::word_t jump_target(logic [25:0] index);
		mips_isa_pkg::word_t pc4;
		pc4 = next_pc + 32'd4;
		return {pc4[31:28], index, 2'b00};
	endfunction

	task automatic check(string name, logic [31:0] exp, logic [31:0] act);
		n_checks++;
		assert (act === exp) else begin
			n_errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic drive_side();
		ex_val = next_rand();
		ex_wdata <= ex_val;
		mem_fwd <= mem_src;
	endtask

	// drive on the rising edge, sample on the falling one
	task automatic issue(mips_isa_pkg::word_t inst);
		@(posedge clk);
		id_pc <= next_pc;
		id_inst <= inst;
		drive_side();
		next_pc = next_pc + 32'd4;
		@(negedge clk);
	endtask

	task automatic hold_cycle();
		@(posedge clk);
		drive_side(); // upstream keeps pc and word
		@(negedge clk);
	endtask

	task automatic decode_case(string name, mips_isa_pkg::word_t inst, logic [31:0] aluop,
		logic [31:0] alusel, logic [31:0] wd, logic [31:0] reg1, logic [31:0] reg2);
		mips_isa_pkg::word_t pc;
		pc = next_pc;
		issue(inst);
		check({name, " stall"}, 0, stall);
		issue(filler);
		check({name, " aluop"}, aluop, ex.aluop);
		check({name, " alusel"}, alusel, ex.alusel);
		check({name, " wd"}, wd, ex.wd);
		check({name, " reg1"}, reg1, ex.reg1);
		check({name, " reg2"}, reg2, ex.reg2);
		check({name, " pc"}, pc, ex.pc);
		check({name, " inst"}, inst, ex.inst);
	endtask

	task automatic fwd_case(string name, logic [4:0] writer, logic use_mem);
		mips_isa_pkg::word_t mval;
		mips_isa_pkg::word_t exp;
		mval = next_rand();
		mem_src.wreg = use_mem;
		mem_src.wd = 5'd20;
		mem_src.wdata = mval;
		issue(enc_i(mips_isa_pkg::OP_ADDIU, 5'd1, writer, 16'h0010));
		issue(enc_r(5'd20, 5'd22, 5'd21, 5'd0, mips_isa_pkg::F_ADD)); // reads r20
		if (writer == 5'd20)
			exp = ex_val;
		else if (use_mem)
			exp = mval;
		else
			exp = regs[20];
		mem_src = '0;
		issue(filler);
		check({name, " reg1"}, exp, ex.reg1);
	endtask

	task automatic branch_case(string name, mips_isa_pkg::word_t inst, logic taken,
		mips_isa_pkg::word_t target, mips_isa_pkg::word_t link);
		issue(inst);
		check({name, " flag"}, taken, branch.flag);
		if (taken)
			check({name, " target"}, target, branch.target);
		issue(filler);
		check({name, " link_addr"}, link, ex.link_addr);
		if (link != 0)
			check({name, " wd"}, 31, ex.wd);
		issue(filler);
		check({name, " delay slot"}, taken, ex.in_delayslot);
	endtask

	task automatic exc_case(string name, mips_isa_pkg::word_t inst, logic [2:0] exc,
		logic wreg);
		issue(inst);
		issue(filler);
		check({name, " except"}, exc, ex.except); // syscall, eret, invalid
		check({name, " wreg"}, wreg, ex.wreg);
	endtask

	always @(negedge clk) begin
		if (rst) begin
			assert (ex.aluop == mips_pipe_pkg::ALU_NOP && !ex.wreg && ex.except == '0
				&& !ex.in_delayslot && !stall && !branch.flag) else begin
				n_errors++;
				$display("Error reset: bundle is not a bubble, or stall or branch is active");
			end
		end
	end

	initial begin
		#((n_instr + 16 + 50) * 8);
		$display("watchdog expired before the tests completed");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		mips_isa_pkg::word_t r;
		mips_isa_pkg::word_t mval;
		rst = 1'b1;
		id_pc = '0;
		id_inst = filler;
		ex_wdata = '0;
		mem_fwd = '0;
		mem_src = '0;
		next_pc = 32'h0040_0000;
		for (int i = 0; i < 32; i++)
			regs[i] = next_rand();
		regs[0] = '0;
		regs[8] = {1'b0, regs[8][30:1], 1'b1}; // positive
		regs[9][31] = 1'b1; // negative
		regs[10] = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("after reset aluop", mips_pipe_pkg::ALU_NOP, ex.aluop);
		check("after reset wreg", 0, ex.wreg);
		check("after reset delay slot", 0, ex.in_delayslot);
		check("after reset stall", 0, stall);
		check("after reset branch", 0, branch.flag);

		r = next_rand();
		decode_case("ori", enc_i(mips_isa_pkg::OP_ORI, 5'd3, 5'd4, r[15:0]),
			mips_pipe_pkg::ALU_OR, mips_pipe_pkg::SEL_LOGIC, 4, regs[3], {16'h0, r[15:0]});
		decode_case("andi", enc_i(mips_isa_pkg::OP_ANDI, 5'd29, 5'd30, r[31:16]),
			mips_pipe_pkg::ALU_AND, mips_pipe_pkg::SEL_LOGIC, 30, regs[29], {16'h0, r[31:16]});
		decode_case("lui", enc_i(mips_isa_pkg::OP_LUI, 5'd0, 5'd28, r[15:0]),
			mips_pipe_pkg::ALU_OR, mips_pipe_pkg::SEL_LOGIC, 28, regs[0], {r[15:0], 16'h0});
		decode_case("addiu", enc_i(mips_isa_pkg::OP_ADDIU, 5'd3, 5'd7, {1'b1, r[14:0]}),
			mips_pipe_pkg::ALU_ADDIU, mips_pipe_pkg::SEL_ARITH, 7, regs[3],
			{17'h1ffff, r[14:0]});
		r = next_rand();
		decode_case("slti", enc_i(mips_isa_pkg::OP_SLTI, 5'd13, 5'd14, r[15:0]),
			mips_pipe_pkg::ALU_SLT, mips_pipe_pkg::SEL_ARITH, 14, regs[13],
			{{16{r[15]}}, r[15:0]});
		decode_case("sll", enc_r(5'd0, 5'd7, 5'd12, r[20:16], mips_isa_pkg::F_SLL),
			mips_pipe_pkg::ALU_SLL, mips_pipe_pkg::SEL_SHIFT, 12, regs[7], {27'd0, r[20:16]});
		decode_case("add", enc_r(5'd13, 5'd14, 5'd12, 5'd0, mips_isa_pkg::F_ADD),
			mips_pipe_pkg::ALU_ADD, mips_pipe_pkg::SEL_ARITH, 12, regs[13], regs[14]);
		decode_case("sub", enc_r(5'd15, 5'd16, 5'd17, 5'd0, mips_isa_pkg::F_SUB),
			mips_pipe_pkg::ALU_SUB, mips_pipe_pkg::SEL_ARITH, 17, regs[15], regs[16]);
		decode_case("nor", enc_r(5'd18, 5'd19, 5'd24, 5'd0, mips_isa_pkg::F_NOR),
			mips_pipe_pkg::ALU_NOR, mips_pipe_pkg::SEL_LOGIC, 24, regs[18], regs[19]);
		decode_case("srav", enc_r(5'd25, 5'd26, 5'd27, 5'd0, mips_isa_pkg::F_SRAV),
			mips_pipe_pkg::ALU_SRAV, mips_pipe_pkg::SEL_SHIFT, 27, regs[25], regs[26]);

		fwd_case("fwd ex over mem", 5'd20, 1'b1);
		fwd_case("fwd mem only", 5'd23, 1'b1);
		fwd_case("fwd none", 5'd23, 1'b0);

		// lw r5 then a reader of r5
		issue(enc_i(mips_isa_pkg::OP_LW, 5'd1, 5'd5, 16'h0004));
		check("lw stall", 0, stall);
		issue(enc_r(5'd5, 5'd2, 5'd6, 5'd0, mips_isa_pkg::F_ADD));
		check("load-use stall", 1, stall);
		mval = next_rand();
		mem_src.wreg = 1'b1;
		mem_src.wd = 5'd5;
		mem_src.wdata = mval;
		hold_cycle();
		check("load-use stall released", 0, stall);
		check("load-use bubble aluop", mips_pipe_pkg::ALU_NOP, ex.aluop);
		check("load-use bubble wreg", 0, ex.wreg);
		mem_src = '0;
		issue(filler);
		check("load-use add aluop", mips_pipe_pkg::ALU_ADD, ex.aluop);
		check("load-use add reg1", mval, ex.reg1);
		check("load-use add reg2", regs[2], ex.reg2);
		issue(enc_i(mips_isa_pkg::OP_LW, 5'd1, 5'd5, 16'h0008));
		issue(enc_r(5'd2, 5'd3, 5'd6, 5'd0, mips_isa_pkg::F_ADD));
		check("independent follower stall", 0, stall);
		issue(filler);

		// a branch on the loaded register waits for the load too
		r = next_rand();
		issue(enc_i(mips_isa_pkg::OP_LW, 5'd1, 5'd5, 16'h000c));
		issue(enc_i(mips_isa_pkg::OP_BEQ, 5'd5, 5'd5, r[15:0]));
		check("load-use branch stall", 1, stall);
		check("load-use branch", 0, branch.flag);
		hold_cycle();
		check("branch after stall", 1, branch.flag);
		issue(filler);

		r = next_rand();
		branch_case("beq taken", enc_i(mips_isa_pkg::OP_BEQ, 5'd8, 5'd8, r[15:0]), 1'b1,
			rel_target(r[15:0]), 0);
		branch_case("beq not taken", enc_i(mips_isa_pkg::OP_BEQ, 5'd8, 5'd9, r[15:0]), 1'b0,
			0, 0);
		branch_case("bne taken", enc_i(mips_isa_pkg::OP_BNE, 5'd8, 5'd9, r[31:16]), 1'b1,
			rel_target(r[31:16]), 0);
		branch_case("bne not taken", enc_i(mips_isa_pkg::OP_BNE, 5'd9, 5'd9, r[31:16]), 1'b0,
			0, 0);
		branch_case("bgtz taken", enc_i(mips_isa_pkg::OP_BGTZ, 5'd8, 5'd0, r[15:0]), 1'b1,
			rel_target(r[15:0]), 0);
		branch_case("bgtz not taken", enc_i(mips_isa_pkg::OP_BGTZ, 5'd10, 5'd0, r[15:0]), 1'b0,
			0, 0);
		r = next_rand();
		branch_case("blez taken", enc_i(mips_isa_pkg::OP_BLEZ, 5'd10, 5'd0, r[15:0]), 1'b1,
			rel_target(r[15:0]), 0);
		branch_case("blez not taken", enc_i(mips_isa_pkg::OP_BLEZ, 5'd8, 5'd0, r[15:0]), 1'b0,
			0, 0);
		branch_case("bgez taken", enc_i(mips_isa_pkg::OP_REGIMM, 5'd10, mips_isa_pkg::RI_BGEZ,
			r[31:16]), 1'b1, rel_target(r[31:16]), 0);
		branch_case("bgez not taken", enc_i(mips_isa_pkg::OP_REGIMM, 5'd9,
			mips_isa_pkg::RI_BGEZ, r[31:16]), 1'b0, 0, 0);
		branch_case("bltz taken", enc_i(mips_isa_pkg::OP_REGIMM, 5'd9, mips_isa_pkg::RI_BLTZ,
			r[15:0]), 1'b1, rel_target(r[15:0]), 0);
		branch_case("bltz not taken", enc_i(mips_isa_pkg::OP_REGIMM, 5'd8,
			mips_isa_pkg::RI_BLTZ, r[15:0]), 1'b0, 0, 0);
		r = next_rand();
		branch_case("j", enc_j(mips_isa_pkg::OP_J, r[25:0]), 1'b1, jump_target(r[25:0]), 0);
		branch_case("jal", enc_j(mips_isa_pkg::OP_JAL, ~r[25:0]), 1'b1, jump_target(~r[25:0]),
			next_pc + 32'd8);
		branch_case("jr", enc_r(5'd11, 5'd0, 5'd0, 5'd0, mips_isa_pkg::F_JR), 1'b1, regs[11], 0);
		branch_case("bltzal", enc_i(mips_isa_pkg::OP_REGIMM, 5'd9, mips_isa_pkg::RI_BLTZAL,
			r[31:16]), 1'b1, rel_target(r[31:16]), next_pc + 32'd8);

		exc_case("syscall", enc_r(5'd0, 5'd0, 5'd0, 5'd0, mips_isa_pkg::F_SYSCALL), 3'b100, 1'b0);
		exc_case("eret", 32'h4200_0018, 3'b010, 1'b0);
		exc_case("mult", enc_r(5'd2, 5'd3, 5'd0, 5'd0, 6'b011000), 3'b001, 1'b0);

		$display("checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- hdl/id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit (
	input  mips_pipe_pkg::ctrl_t   ctrl_i,
	input  mips_isa_pkg::word_t    pc_i,
	input  mips_isa_pkg::inst_u    inst_i,
	input  mips_isa_pkg::word_t    op1_i,
	input  mips_isa_pkg::word_t    op2_i,
	input  logic                   stall_i,
	output mips_pipe_pkg::branch_t branch_o,
	output mips_isa_pkg::word_t    link_addr_o,
	output logic                   next_in_delayslot_o
);

	mips_isa_pkg::word_t pc_plus4;
	mips_isa_pkg::word_t pc_plus8;
	mips_isa_pkg::word_t rel_target;
	mips_isa_pkg::word_t target;
	logic                taken;
	logic                link;

	assign pc_plus4 = pc_i + 32'd4;
	assign pc_plus8 = pc_i + 32'd8;
	assign rel_target = pc_plus4 + {{14{inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};

	always_comb begin
		taken = 1'b1;
		target = rel_target;
		case (ctrl_i.br)
		mips_pipe_pkg::BR_JUMP: target = {pc_plus4[31:28], inst_i.j.index, 2'b00};
		mips_pipe_pkg::BR_REG: target = op1_i;
		mips_pipe_pkg::BR_EQ: taken = (op1_i == op2_i);
		mips_pipe_pkg::BR_NE: taken = (op1_i != op2_i);
		mips_pipe_pkg::BR_GTZ: taken = !op1_i[31] && (op1_i != '0);
		mips_pipe_pkg::BR_LEZ: taken = op1_i[31] || (op1_i == '0);
		mips_pipe_pkg::BR_GEZ: taken = !op1_i[31];
		mips_pipe_pkg::BR_LTZ: taken = op1_i[31];
		default: taken = 1'b0;
		endcase
	end

	// operands are not final while stalled
	assign branch_o.flag = taken && !stall_i;
	assign branch_o.target = branch_o.flag ? target : '0;
	assign next_in_delayslot_o = branch_o.flag;

	// linking forms write pc+8 whether taken or not
	assign link = ctrl_i.aluop inside {mips_pipe_pkg::ALU_JAL, mips_pipe_pkg::ALU_JALR,
		mips_pipe_pkg::ALU_BGEZAL, mips_pipe_pkg::ALU_BLTZAL};
	assign link_addr_o = link ? pc_plus8 : '0;

endmodule

//--- hdl/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
	input  mips_isa_pkg::inst_u    inst_i,
	output mips_pipe_pkg::ctrl_t   ctrl_o,
	output mips_pipe_pkg::rf_req_t rf_req_o
);

	mips_isa_pkg::word_t imm_sext;
	mips_isa_pkg::word_t imm_zext;

	assign imm_sext = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
	assign imm_zext = {16'h0000, inst_i.i.imm};

	always_comb begin
		ctrl_o = '0;
		ctrl_o.aluop = mips_pipe_pkg::ALU_NOP;
		ctrl_o.alusel = mips_pipe_pkg::SEL_NOP;
		ctrl_o.br = mips_pipe_pkg::BR_NONE;
		ctrl_o.wd = inst_i.r.rd;
		ctrl_o.except.invalid = 1'b1; // cleared by every known word
		rf_req_o.re1 = 1'b0;
		rf_req_o.addr1 = inst_i.r.rs;
		rf_req_o.re2 = 1'b0;
		rf_req_o.addr2 = inst_i.r.rt;

		case (inst_i.r.opcode)
		mips_isa_pkg::OP_SPECIAL: begin
			ctrl_o.wreg = 1'b1;
			ctrl_o.except.invalid = 1'b0;
			rf_req_o.re1 = 1'b1;
			rf_req_o.re2 = 1'b1;
			case (inst_i.r.funct)
			mips_isa_pkg::F_AND: ctrl_o.aluop = mips_pipe_pkg::ALU_AND;
			mips_isa_pkg::F_OR: ctrl_o.aluop = mips_pipe_pkg::ALU_OR;
			mips_isa_pkg::F_XOR: ctrl_o.aluop = mips_pipe_pkg::ALU_XOR;
			mips_isa_pkg::F_NOR: ctrl_o.aluop = mips_pipe_pkg::ALU_NOR;
			mips_isa_pkg::F_SLL: ctrl_o.aluop = mips_pipe_pkg::ALU_SLL;
			mips_isa_pkg::F_SRL: ctrl_o.aluop = mips_pipe_pkg::ALU_SRL;
			mips_isa_pkg::F_SRA: ctrl_o.aluop = mips_pipe_pkg::ALU_SRA;
			mips_isa_pkg::F_SLLV: ctrl_o.aluop = mips_pipe_pkg::ALU_SLLV;
			mips_isa_pkg::F_SRLV: ctrl_o.aluop = mips_pipe_pkg::ALU_SRLV;
			mips_isa_pkg::F_SRAV: ctrl_o.aluop = mips_pipe_pkg::ALU_SRAV;
			mips_isa_pkg::F_ADD: ctrl_o.aluop = mips_pipe_pkg::ALU_ADD;
			mips_isa_pkg::F_ADDU: ctrl_o.aluop = mips_pipe_pkg::ALU_ADDU;
			mips_isa_pkg::F_SUB: ctrl_o.aluop = mips_pipe_pkg::ALU_SUB;
			mips_isa_pkg::F_SUBU: ctrl_o.aluop = mips_pipe_pkg::ALU_SUBU;
			mips_isa_pkg::F_SLT: ctrl_o.aluop = mips_pipe_pkg::ALU_SLT;
			mips_isa_pkg::F_SLTU: ctrl_o.aluop = mips_pipe_pkg::ALU_SLTU;
			mips_isa_pkg::F_JR: ctrl_o.aluop = mips_pipe_pkg::ALU_JR;
			mips_isa_pkg::F_JALR: ctrl_o.aluop = mips_pipe_pkg::ALU_JALR;
			mips_isa_pkg::F_SYSCALL: ctrl_o.aluop = mips_pipe_pkg::ALU_SYSCALL;
			default: begin
				ctrl_o.wreg = 1'b0;
				ctrl_o.except.invalid = 1'b1;
				rf_req_o.re1 = 1'b0;
				rf_req_o.re2 = 1'b0;
			end
			endcase
			case (inst_i.r.funct)
			mips_isa_pkg::F_AND, mips_isa_pkg::F_OR,
			mips_isa_pkg::F_XOR, mips_isa_pkg::F_NOR:
				ctrl_o.alusel = mips_pipe_pkg::SEL_LOGIC;
			mips_isa_pkg::F_SLLV, mips_isa_pkg::F_SRLV, mips_isa_pkg::F_SRAV:
				ctrl_o.alusel = mips_pipe_pkg::SEL_SHIFT;
			mips_isa_pkg::F_ADD, mips_isa_pkg::F_ADDU, mips_isa_pkg::F_SUB,
			mips_isa_pkg::F_SUBU, mips_isa_pkg::F_SLT, mips_isa_pkg::F_SLTU:
				ctrl_o.alusel = mips_pipe_pkg::SEL_ARITH;
			mips_isa_pkg::F_SLL, mips_isa_pkg::F_SRL, mips_isa_pkg::F_SRA: begin
				// rt value on port 1, shamt rides in as operand 2
				ctrl_o.alusel = mips_pipe_pkg::SEL_SHIFT;
				ctrl_o.imm = {27'd0, inst_i.r.shamt};
				rf_req_o.addr1 = inst_i.r.rt;
				rf_req_o.re2 = 1'b0;
			end
			mips_isa_pkg::F_JR, mips_isa_pkg::F_JALR: begin
				ctrl_o.alusel = mips_pipe_pkg::SEL_JUMP_BRANCH;
				ctrl_o.br = mips_pipe_pkg::BR_REG;
				ctrl_o.wreg = (inst_i.r.funct == mips_isa_pkg::F_JALR);
				rf_req_o.re2 = 1'b0;
			end
			mips_isa_pkg::F_SYSCALL: begin
				ctrl_o.wreg = 1'b0;
				ctrl_o.except.syscall = 1'b1;
				rf_req_o.re1 = 1'b0;
				rf_req_o.re2 = 1'b0;
			end
			default: ;
			endcase
		end
		mips_isa_pkg::OP_REGIMM: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_JUMP_BRANCH;
			ctrl_o.except.invalid = 1'b0;
			rf_req_o.re1 = 1'b1;
			case (mips_isa_pkg::regimm_e'(inst_i.i.rt))
			mips_isa_pkg::RI_BLTZ: begin
				ctrl_o.aluop = mips_pipe_pkg::ALU_BLTZ;
				ctrl_o.br = mips_pipe_pkg::BR_LTZ;
			end
			mips_isa_pkg::RI_BGEZ: begin
				ctrl_o.aluop = mips_pipe_pkg::ALU_BGEZ;
				ctrl_o.br = mips_pipe_pkg::BR_GEZ;
			end
			mips_isa_pkg::RI_BLTZAL: begin
				ctrl_o.aluop = mips_pipe_pkg::ALU_BLTZAL;
				ctrl_o.br = mips_pipe_pkg::BR_LTZ;
				ctrl_o.wreg = 1'b1;
				ctrl_o.wd = mips_isa_pkg::LINK_REG;
			end
			mips_isa_pkg::RI_BGEZAL: begin
				ctrl_o.aluop = mips_pipe_pkg::ALU_BGEZAL;
				ctrl_o.br = mips_pipe_pkg::BR_GEZ;
				ctrl_o.wreg = 1'b1;
				ctrl_o.wd = mips_isa_pkg::LINK_REG;
			end
			default: begin
				ctrl_o.alusel = mips_pipe_pkg::SEL_NOP;
				ctrl_o.except.invalid = 1'b1;
				rf_req_o.re1 = 1'b0;
			end
			endcase
		end
		mips_isa_pkg::OP_COP0: begin
			if (inst_i == mips_isa_pkg::ERET_WORD) begin // other cop0 words stay invalid
				ctrl_o.aluop = mips_pipe_pkg::ALU_ERET;
				ctrl_o.except.invalid = 1'b0;
				ctrl_o.except.eret = 1'b1;
			end
		end
		mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI,
		mips_isa_pkg::OP_LUI: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_LOGIC;
			ctrl_o.wreg = 1'b1;
			ctrl_o.wd = inst_i.i.rt;
			ctrl_o.except.invalid = 1'b0;
			ctrl_o.imm = (inst_i.i.opcode == mips_isa_pkg::OP_LUI) ?
				{inst_i.i.imm, 16'h0000} : imm_zext;
			rf_req_o.re1 = 1'b1; // rs is r0 for lui
		end
		mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI,
		mips_isa_pkg::OP_SLTIU: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_ARITH;
			ctrl_o.wreg = 1'b1;
			ctrl_o.wd = inst_i.i.rt;
			ctrl_o.except.invalid = 1'b0;
			ctrl_o.imm = imm_sext;
			rf_req_o.re1 = 1'b1;
		end
		mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_LOAD_STORE;
			ctrl_o.wreg = (inst_i.i.opcode == mips_isa_pkg::OP_LW);
			ctrl_o.wd = inst_i.i.rt;
			ctrl_o.except.invalid = 1'b0;
			ctrl_o.imm = imm_sext; // address offset
			rf_req_o.re1 = 1'b1;
			rf_req_o.re2 = (inst_i.i.opcode == mips_isa_pkg::OP_SW);
		end
		mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_JUMP_BRANCH;
			ctrl_o.br = (inst_i.i.opcode == mips_isa_pkg::OP_BEQ) ?
				mips_pipe_pkg::BR_EQ : mips_pipe_pkg::BR_NE;
			ctrl_o.except.invalid = 1'b0;
			rf_req_o.re1 = 1'b1;
			rf_req_o.re2 = 1'b1;
		end
		mips_isa_pkg::OP_BGTZ, mips_isa_pkg::OP_BLEZ: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_JUMP_BRANCH;
			ctrl_o.br = (inst_i.i.opcode == mips_isa_pkg::OP_BGTZ) ?
				mips_pipe_pkg::BR_GTZ : mips_pipe_pkg::BR_LEZ;
			ctrl_o.except.invalid = 1'b0;
			rf_req_o.re1 = 1'b1;
		end
		mips_isa_pkg::OP_J, mips_isa_pkg::OP_JAL: begin
			ctrl_o.alusel = mips_pipe_pkg::SEL_JUMP_BRANCH;
			ctrl_o.br = mips_pipe_pkg::BR_JUMP;
			ctrl_o.wreg = (inst_i.j.opcode == mips_isa_pkg::OP_JAL);
			ctrl_o.wd = mips_isa_pkg::LINK_REG;
			ctrl_o.except.invalid = 1'b0;
		end
		default: ;
		endcase

		// operation codes outside SPECIAL and REGIMM
		case (inst_i.i.opcode)
		mips_isa_pkg::OP_ANDI: ctrl_o.aluop = mips_pipe_pkg::ALU_AND;
		mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_LUI: ctrl_o.aluop = mips_pipe_pkg::ALU_OR;
		mips_isa_pkg::OP_XORI: ctrl_o.aluop = mips_pipe_pkg::ALU_XOR;
		mips_isa_pkg::OP_ADDI: ctrl_o.aluop = mips_pipe_pkg::ALU_ADDI;
		mips_isa_pkg::OP_ADDIU: ctrl_o.aluop = mips_pipe_pkg::ALU_ADDIU;
		mips_isa_pkg::OP_SLTI: ctrl_o.aluop = mips_pipe_pkg::ALU_SLT;
		mips_isa_pkg::OP_SLTIU: ctrl_o.aluop = mips_pipe_pkg::ALU_SLTU;
		mips_isa_pkg::OP_LW: ctrl_o.aluop = mips_pipe_pkg::ALU_LW;
		mips_isa_pkg::OP_SW: ctrl_o.aluop = mips_pipe_pkg::ALU_SW;
		mips_isa_pkg::OP_BEQ: ctrl_o.aluop = mips_pipe_pkg::ALU_BEQ;
		mips_isa_pkg::OP_BNE: ctrl_o.aluop = mips_pipe_pkg::ALU_BNE;
		mips_isa_pkg::OP_BGTZ: ctrl_o.aluop = mips_pipe_pkg::ALU_BGTZ;
		mips_isa_pkg::OP_BLEZ: ctrl_o.aluop = mips_pipe_pkg::ALU_BLEZ;
		mips_isa_pkg::OP_J: ctrl_o.aluop = mips_pipe_pkg::ALU_J;
		mips_isa_pkg::OP_JAL: ctrl_o.aluop = mips_pipe_pkg::ALU_JAL;
		default: ;
		endcase
	end

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      stall_i,
	input  mips_pipe_pkg::ctrl_t      ctrl_i,
	input  mips_isa_pkg::word_t       op1_i,
	input  mips_isa_pkg::word_t       op2_i,
	input  mips_isa_pkg::word_t       link_addr_i,
	input  logic                      next_in_delayslot_i,
	input  mips_isa_pkg::word_t       pc_i,
	input  mips_isa_pkg::word_t       inst_i,
	output mips_pipe_pkg::ex_bundle_t ex_o
);

	logic in_ds_q; // previous accepted word was a taken branch

	always_ff @(posedge clk) begin
		if (rst_i) begin
			in_ds_q <= 1'b0;
		end else if (!stall_i) begin
			in_ds_q <= next_in_delayslot_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || stall_i) begin
			// bubble
			ex_o <= '0;
			ex_o.aluop <= mips_pipe_pkg::ALU_NOP;
			ex_o.alusel <= mips_pipe_pkg::SEL_NOP;
		end else begin
			ex_o.aluop <= ctrl_i.aluop;
			ex_o.alusel <= ctrl_i.alusel;
			ex_o.reg1 <= op1_i;
			ex_o.reg2 <= op2_i;
			ex_o.wd <= ctrl_i.wd;
			ex_o.wreg <= ctrl_i.wreg;
			ex_o.link_addr <= link_addr_i;
			ex_o.in_delayslot <= in_ds_q;
			ex_o.except <= ctrl_i.except;
			ex_o.pc <= pc_i;
			ex_o.inst <= inst_i;
		end
	end

endmodule

//--- hdl/id_operand_sel.sv
`timescale 1ns/1ps

module id_operand_sel (
	input  logic                    re_i,
	input  mips_isa_pkg::reg_addr_t addr_i,
	input  mips_isa_pkg::word_t     rf_data_i,
	input  mips_isa_pkg::word_t     imm_i,
	input  mips_pipe_pkg::fwd_t     ex_fwd_i,
	input  logic                    ex_is_load_i,
	input  mips_pipe_pkg::fwd_t     mem_fwd_i,
	output mips_isa_pkg::word_t     operand_o,
	output logic                    load_use_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 is matched like any other register
	assign ex_hit = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	// lw data only exists after memory
	assign load_use_o = re_i && ex_is_load_i && (ex_fwd_i.wd == addr_i);

	always_comb begin
		if (!re_i) begin
			operand_o = imm_i;
		end else if (load_use_o) begin
			operand_o = '0; // stage stalls, value unused
		end else if (ex_hit) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic                      clk,
	input  logic                      rst_i,
	input  mips_isa_pkg::word_t       pc_i,
	input  mips_isa_pkg::word_t       inst_i,
	input  mips_isa_pkg::word_t       rf_data1_i,
	input  mips_isa_pkg::word_t       rf_data2_i,
	input  mips_isa_pkg::word_t       ex_wdata_i,
	input  mips_pipe_pkg::fwd_t       mem_fwd_i,
	output mips_pipe_pkg::rf_req_t    rf_req_o,
	output logic                      stall_o,
	output mips_pipe_pkg::branch_t    branch_o,
	output mips_pipe_pkg::ex_bundle_t ex_o
);

	mips_isa_pkg::inst_u  inst_w;
	mips_pipe_pkg::ctrl_t ctrl;
	mips_pipe_pkg::fwd_t  ex_fwd;
	logic                 ex_is_load;
	mips_isa_pkg::word_t  op1;
	mips_isa_pkg::word_t  op2;
	logic                 load_use1;
	logic                 load_use2;
	mips_isa_pkg::word_t  link_addr;
	logic                 next_in_ds;

	assign inst_w = inst_i;

	// execute-stage writer comes from our own ID/EX register
	assign ex_fwd.wreg = ex_o.wreg;
	assign ex_fwd.wd = ex_o.wd;
	assign ex_fwd.wdata = ex_wdata_i;
	assign ex_is_load = (ex_o.aluop == mips_pipe_pkg::ALU_LW);

	assign stall_o = load_use1 | load_use2;

	id_decoder u_decoder (
		.inst_i   (inst_w),
		.ctrl_o   (ctrl),
		.rf_req_o (rf_req_o)
	);

	id_operand_sel u_op1 (
		.re_i         (rf_req_o.re1),
		.addr_i       (rf_req_o.addr1),
		.rf_data_i    (rf_data1_i),
		.imm_i        (ctrl.imm),
		.ex_fwd_i     (ex_fwd),
		.ex_is_load_i (ex_is_load),
		.mem_fwd_i    (mem_fwd_i),
		.operand_o    (op1),
		.load_use_o   (load_use1)
	);

	id_operand_sel u_op2 (
		.re_i         (rf_req_o.re2),
		.addr_i       (rf_req_o.addr2),
		.rf_data_i    (rf_data2_i),
		.imm_i        (ctrl.imm),
		.ex_fwd_i     (ex_fwd),
		.ex_is_load_i (ex_is_load),
		.mem_fwd_i    (mem_fwd_i),
		.operand_o    (op2),
		.load_use_o   (load_use2)
	);

	id_branch_unit u_branch (
		.ctrl_i              (ctrl),
		.pc_i                (pc_i),
		.inst_i              (inst_w),
		.op1_i               (op1),
		.op2_i               (op2),
		.stall_i             (stall_o),
		.branch_o            (branch_o),
		.link_addr_o         (link_addr),
		.next_in_delayslot_o (next_in_ds)
	);

	id_ex_reg u_id_ex (
		.clk                 (clk),
		.rst_i               (rst_i),
		.stall_i             (stall_o),
		.ctrl_i              (ctrl),
		.op1_i               (op1),
		.op2_i               (op2),
		.link_addr_i         (link_addr),
		.next_in_delayslot_i (next_in_ds),
		.pc_i                (pc_i),
		.inst_i              (inst_i),
		.ex_o                (ex_o)
	);

endmodule

//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// primary opcodes still decoded
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_COP0    = 6'b010000,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	// SPECIAL function field
	typedef enum logic [5:0] {
		F_SLL     = 6'b000000,
		F_SRL     = 6'b000010,
		F_SRA     = 6'b000011,
		F_SLLV    = 6'b000100,
		F_SRLV    = 6'b000110,
		F_SRAV    = 6'b000111,
		F_JR      = 6'b001000,
		F_JALR    = 6'b001001,
		F_SYSCALL = 6'b001100,
		F_ADD     = 6'b100000,
		F_ADDU    = 6'b100001,
		F_SUB     = 6'b100010,
		F_SUBU    = 6'b100011,
		F_AND     = 6'b100100,
		F_OR      = 6'b100101,
		F_XOR     = 6'b100110,
		F_NOR     = 6'b100111,
		F_SLT     = 6'b101010,
		F_SLTU    = 6'b101011
	} funct_e;

	// REGIMM branches, selected by the rt field
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

	typedef struct packed {
		opcode_e    opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] index;
	} j_fmt_t;

	// same word seen as R, I or J format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} inst_u;

	localparam word_t     ERET_WORD = 32'h4200_0018;
	localparam reg_addr_t LINK_REG  = 5'd31;

endpackage

//--- hdl/mips_pipe_pkg.sv
package mips_pipe_pkg;

	typedef enum logic [7:0] {
		ALU_NOP,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_ADDI, ALU_ADDIU,
		ALU_JR, ALU_JALR, ALU_J, ALU_JAL,
		ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
		ALU_BGEZ, ALU_BLTZ, ALU_BGEZAL, ALU_BLTZAL,
		ALU_LW, ALU_SW,
		ALU_SYSCALL, ALU_ERET
	} aluop_e;

	// result group picked in execute
	typedef enum logic [2:0] {
		SEL_NOP,
		SEL_LOGIC,
		SEL_SHIFT,
		SEL_ARITH,
		SEL_JUMP_BRANCH,
		SEL_LOAD_STORE
	} alusel_e;

	// how the branch unit treats the word
	typedef enum logic [3:0] {
		BR_NONE,
		BR_JUMP,  // J, JAL
		BR_REG,   // JR, JALR
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} brkind_e;

	typedef struct packed {
		logic syscall;
		logic eret;
		logic invalid;
	} except_t;

	typedef struct packed {
		logic                    re1;
		mips_isa_pkg::reg_addr_t addr1;
		logic                    re2;
		mips_isa_pkg::reg_addr_t addr2;
	} rf_req_t;

	typedef struct packed {
		logic                    wreg;
		mips_isa_pkg::reg_addr_t wd;
		mips_isa_pkg::word_t     wdata;
	} fwd_t;

	typedef struct packed {
		aluop_e                  aluop;
		alusel_e                 alusel;
		logic                    wreg;
		mips_isa_pkg::reg_addr_t wd;
		mips_isa_pkg::word_t     imm;
		brkind_e                 br;
		except_t                 except;
	} ctrl_t;

	typedef struct packed {
		logic                flag;
		mips_isa_pkg::word_t target;
	} branch_t;

	typedef struct packed {
		aluop_e                  aluop;
		alusel_e                 alusel;
		mips_isa_pkg::word_t     reg1;
		mips_isa_pkg::word_t     reg2;
		mips_isa_pkg::reg_addr_t wd;
		logic                    wreg;
		mips_isa_pkg::word_t     link_addr;
		logic                    in_delayslot;
		except_t                 except;
		mips_isa_pkg::word_t     pc;
		mips_isa_pkg::word_t     inst;
	} ex_bundle_t;

endpackage

//--- src.f
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/id_decoder.sv
hdl/id_operand_sel.sv
hdl/id_branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
bench/tb_id_stage.sv
